// File: bench/ref_model.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

logic [31:0] model_regs [32];  // architectural state, program order

function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic sub,
                                          input logic arith, input logic [31:0] a,
                                          input logic [31:0] b);
  logic [31:0] y;
  case (f3)
    riscv_isa_pkg::F3_ADD:  y = sub ? a - b : a + b;
    riscv_isa_pkg::F3_SLL:  y = a << b[4:0];
    riscv_isa_pkg::F3_SLT:  y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    riscv_isa_pkg::F3_SLTU: y = (a < b) ? 32'd1 : 32'd0;
    riscv_isa_pkg::F3_XOR:  y = a ^ b;
    riscv_isa_pkg::F3_SR: begin
      if (arith) y = $signed(a) >>> b[4:0];
      else y = a >> b[4:0];
    end
    riscv_isa_pkg::F3_OR:   y = a | b;
    default:                y = a & b;
  endcase
  return y;
endfunction

function automatic logic [31:0] expected_result(input riscv_isa_pkg::inst_word_u inst,
                                                input logic [31:0] pc,
                                                input logic [31:0] regs [32]);
  logic [31:0] result;
  logic [31:0] a, b, imm_i, imm_u;
  logic        alt;
  a      = (inst.r_fmt.rs1 == 5'd0) ? 32'd0 : regs[inst.r_fmt.rs1];
  b      = (inst.r_fmt.rs2 == 5'd0) ? 32'd0 : regs[inst.r_fmt.rs2];
  imm_i  = {{20{inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};
  imm_u  = {inst.u_fmt.imm20, 12'h000};
  alt    = inst.r_fmt.funct7[5];  // bit 30, also marks srai
  case (inst.r_fmt.opcode)
    riscv_isa_pkg::OPC_OP:     result = alu_model(inst.r_fmt.funct3, alt, alt, a, b);
    riscv_isa_pkg::OPC_OP_IMM: result = alu_model(inst.i_fmt.funct3, 1'b0, alt, a, imm_i);
    riscv_isa_pkg::OPC_LUI:    result = imm_u;
    riscv_isa_pkg::OPC_AUIPC:  result = pc + imm_u;
    default:                   result = 32'd0;  // no-op
  endcase
  return result;
endfunction

function automatic logic [pipe_pkg::REG_W-1:0] expected_rd(
    input riscv_isa_pkg::inst_word_u inst);
  case (inst.r_fmt.opcode)
    riscv_isa_pkg::OPC_OP, riscv_isa_pkg::OPC_OP_IMM,
    riscv_isa_pkg::OPC_LUI, riscv_isa_pkg::OPC_AUIPC: return inst.r_fmt.rd;
    default: return '0;
  endcase
endfunction

task automatic model_write(input logic [pipe_pkg::REG_W-1:0] rd, input logic [31:0] data);
  if (rd != '0) model_regs[rd] = data;  // x0 stays zero
endtask

`endif

// File: bench/core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_tb;

  localparam int READY_TIMEOUT  = 200;
  localparam int RETIRE_TIMEOUT = 200;
  localparam int RANDOM_COUNT   = 400;

  logic                       clock;
  logic                       reset;
  logic                       inst_valid;
  logic [31:0]                inst;
  logic [31:0]                inst_pc;
  logic                       inst_ready;
  logic                       retire_valid;
  logic [pipe_pkg::REG_W-1:0] retire_rd;
  logic [31:0]                retire_data;
  logic [31:0]                retire_pc;

  logic [pipe_pkg::REG_W-1:0] exp_rd_q [$];
  logic [31:0]                exp_data_q [$];
  logic [31:0]                exp_pc_q [$];
  logic [31:0]                pc_next;
  int                         seed;

  `include "ref_model.svh"

  core_top i_dut (
    .clock(clock), .reset(reset), .inst_valid(inst_valid), .inst(inst),
    .inst_pc(inst_pc), .inst_ready(inst_ready), .retire_valid(retire_valid),
    .retire_rd(retire_rd), .retire_data(retire_data), .retire_pc(retire_pc)
  );

  always #20 clock = ~clock;

  task automatic halt_on_failure();
    $display("Errors found");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      $display("Error: %s is 0x%h, expected 0x%h", name, got, want);
      halt_on_failure();
    end
  endtask

  task automatic check_reg_index(input string name, input logic [pipe_pkg::REG_W-1:0] got,
                                 input logic [pipe_pkg::REG_W-1:0] want);
    if (got !== want) begin
      $display("Error: %s is 0x%h, expected 0x%h", name, got, want);
      halt_on_failure();
    end
  endtask

  task automatic expect_flag(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("Error: %s is 0x%h, expected 0x%h", name, got, want);
      halt_on_failure();
    end
  endtask

  function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, riscv_isa_pkg::OPC_OP};
  endfunction

  function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, riscv_isa_pkg::OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] encode_u(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  // called at rising edge + 1 ns, returns at the edge + 1 ns after the transfer
  task automatic send_inst(input logic [31:0] word);
    int          waited;
    logic [31:0] data;
    inst_valid = 1'b1;
    inst       = word;
    inst_pc    = pc_next;
    waited     = 0;
    while (!inst_ready) begin
      @(posedge clock);
      #1;
      waited++;
      if (waited > READY_TIMEOUT) begin
        $display("Timed out waiting for inst_ready");
        halt_on_failure();
      end
    end
    data = expected_result(word, pc_next, model_regs);
    exp_rd_q.push_back(expected_rd(word));
    exp_data_q.push_back(data);
    exp_pc_q.push_back(pc_next);
    model_write(expected_rd(word), data);
    pc_next = pc_next + 32'd4;
    @(posedge clock);  // transfer edge
    #1;
    inst_valid = 1'b0;
  endtask

  task automatic send_random();
    int          kind;
    logic [4:0]  rd, rs1, rs2, shamt;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic        alt;
    kind  = {$random(seed)} % 4;
    rd    = 5'($random(seed) & 7);  // x0..x7 so hazards come often
    rs1   = 5'($random(seed) & 7);
    rs2   = 5'($random(seed) & 7);
    f3    = 3'($random(seed));
    shamt = 5'($random(seed));
    alt   = 1'($random(seed));
    case (kind)
      0: begin
        if (alt && (f3 == riscv_isa_pkg::F3_ADD || f3 == riscv_isa_pkg::F3_SR))
          send_inst(encode_r(7'h20, rs2, rs1, f3, rd));
        else
          send_inst(encode_r(7'h00, rs2, rs1, f3, rd));
      end
      1: begin
        if (f3 == riscv_isa_pkg::F3_SLL) imm = {7'h00, shamt};
        else if (f3 == riscv_isa_pkg::F3_SR) imm = {1'b0, alt, 5'h00, shamt};
        else imm = 12'($random(seed));
        send_inst(encode_i(imm, rs1, f3, rd));
      end
      2: send_inst(encode_u(20'($random(seed)), rd, riscv_isa_pkg::OPC_LUI));
      default: send_inst(encode_u(20'($random(seed)), rd, riscv_isa_pkg::OPC_AUIPC));
    endcase
  endtask

  initial begin : compare_retirements
    int quiet;
    quiet = 0;
    forever begin
      @(negedge clock);
      if (retire_valid === 1'b1) begin
        if (exp_rd_q.size() == 0) begin
          $display("A retirement came out with no instruction outstanding");
          halt_on_failure();
        end
        check_reg_index("retire_rd", retire_rd, exp_rd_q.pop_front());
        check_word("retire_data", retire_data, exp_data_q.pop_front());
        check_word("retire_pc", retire_pc, exp_pc_q.pop_front());
        quiet = 0;
      end else if (exp_rd_q.size() != 0) begin
        quiet++;
        if (quiet > RETIRE_TIMEOUT) begin
          $display("Timed out waiting for the next retirement");
          halt_on_failure();
        end
      end else begin
        quiet = 0;
      end
    end
  end

  initial begin : run_program
    int waited;
    clock       = 1'b0;
    reset       = 1'b1;
    inst_valid  = 1'b0;
    inst        = '0;
    inst_pc     = '0;
    seed        = 32494;
    pc_next     = 32'h0;
    for (int i = 0; i < 32; i++) model_regs[i] = '0;
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;
    expect_flag("inst_ready", inst_ready, 1'b0);
    @(posedge clock);
    #1;
    expect_flag("inst_ready", inst_ready, 1'b1);
    repeat (4) begin
      expect_flag("retire_valid", retire_valid, 1'b0);
      @(posedge clock);
      #1;
    end

    // every alu code, operands independent of the previous result
    send_inst(encode_i(12'h123, 5'd0, riscv_isa_pkg::F3_ADD, 5'd1));
    send_inst(encode_i(12'hffb, 5'd0, riscv_isa_pkg::F3_ADD, 5'd2));
    send_inst(encode_u(20'h80000, 5'd3, riscv_isa_pkg::OPC_LUI));
    send_inst(encode_u(20'h12345, 5'd4, riscv_isa_pkg::OPC_AUIPC));
    for (int f = 0; f < 8; f++) begin
      send_inst(encode_r(7'h00, 5'd2, 5'd1, 3'(f), 5'(8 + f)));
      if (f == 1 || f == 5) send_inst(encode_i(12'(f * 5), 5'd3, 3'(f), 5'(16 + f)));
      else send_inst(encode_i(12'h7a5 - 12'(f), 5'd3, 3'(f), 5'(16 + f)));
    end
    send_inst(encode_r(7'h20, 5'd2, 5'd1, riscv_isa_pkg::F3_ADD, 5'd24));  // sub
    send_inst(encode_r(7'h20, 5'd1, 5'd3, riscv_isa_pkg::F3_SR, 5'd25));   // sra
    send_inst(encode_i(12'h41f, 5'd3, riscv_isa_pkg::F3_SR, 5'd26));       // srai 31

    // lui/auipc whose rs fields point at the busy rd
    send_inst(encode_i(12'h00c, 5'd0, riscv_isa_pkg::F3_ADD, 5'd5));
    send_inst(encode_u(20'ha0528, 5'd6, riscv_isa_pkg::OPC_LUI));
    send_inst(encode_u(20'hf0630, 5'd7, riscv_isa_pkg::OPC_AUIPC));

    // back-to-back dependences
    send_inst(encode_i(12'h00a, 5'd0, riscv_isa_pkg::F3_ADD, 5'd1));
    send_inst(encode_r(7'h00, 5'd0, 5'd1, riscv_isa_pkg::F3_ADD, 5'd2));  // on rs1
    send_inst(encode_r(7'h20, 5'd2, 5'd0, riscv_isa_pkg::F3_ADD, 5'd3));  // on rs2
    send_inst(encode_r(7'h00, 5'd3, 5'd3, riscv_isa_pkg::F3_ADD, 5'd4));  // on both
    send_inst(encode_r(7'h00, 5'd3, 5'd4, riscv_isa_pkg::F3_SLTU, 5'd5));
    send_inst(encode_r(7'h00, 5'd5, 5'd5, riscv_isa_pkg::F3_AND, 5'd6));
    send_inst(encode_i(12'h055, 5'd6, riscv_isa_pkg::F3_XOR, 5'd7));

    // long shifts and their dependents
    send_inst(encode_i(12'h01f, 5'd0, riscv_isa_pkg::F3_ADD, 5'd6));
    send_inst(encode_r(7'h00, 5'd6, 5'd5, riscv_isa_pkg::F3_SLL, 5'd7));
    send_inst(encode_i(12'h001, 5'd0, riscv_isa_pkg::F3_ADD, 5'd8));  // held behind it
    send_inst(encode_i(12'h41e, 5'd7, riscv_isa_pkg::F3_SR, 5'd9));
    send_inst(encode_r(7'h00, 5'd6, 5'd9, riscv_isa_pkg::F3_SR, 5'd10));
    send_inst(encode_r(7'h00, 5'd9, 5'd7, riscv_isa_pkg::F3_ADD, 5'd11));

    // x0 as destination and source
    send_inst(encode_i(12'h005, 5'd1, riscv_isa_pkg::F3_ADD, 5'd0));
    send_inst(encode_r(7'h00, 5'd1, 5'd0, riscv_isa_pkg::F3_ADD, 5'd12));
    send_inst(encode_r(7'h00, 5'd0, 5'd0, riscv_isa_pkg::F3_OR, 5'd0));
    send_inst(encode_r(7'h00, 5'd0, 5'd0, riscv_isa_pkg::F3_OR, 5'd13));
    send_inst(32'h0000006f);  // jal, retires as a no-op

    repeat (RANDOM_COUNT) send_random();

    waited = 0;
    while (exp_rd_q.size() != 0) begin
      @(posedge clock);
      #1;
      waited++;
      if (waited > RETIRE_TIMEOUT) begin
        $display("Timed out waiting for the last instructions to retire");
        halt_on_failure();
      end
    end
    repeat (4) @(posedge clock);
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+bench
verilog/riscv_isa_pkg.sv
verilog/pipe_pkg.sv
verilog/inst_decoder.sv
verilog/reg_file.sv
verilog/issue_stage.sv
verilog/alu_execute.sv
verilog/core_top.sv
bench/core_tb.sv

// File: verilog/alu_execute.sv
`timescale 1ns/1ps
`default_nettype none

module alu_execute (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       issue_valid,
  input  logic [3:0]                 issue_op,
  input  logic [31:0]                issue_a,
  input  logic [31:0]                issue_b,
  input  logic [31:0]                issue_pc,
  input  logic [pipe_pkg::REG_W-1:0] issue_rd,
  output logic                       exe_ready,
  output logic [pipe_pkg::REG_W-1:0] busy_rd,
  output logic                       retire_valid,
  output logic [pipe_pkg::REG_W-1:0] retire_rd,
  output logic [31:0]                retire_data,
  output logic [31:0]                retire_pc
);

  logic                       busy;
  logic                       accept;
  logic [3:0]                 op_q;
  logic [31:0]                acc_q, b_q, pc_q;
  logic [pipe_pkg::REG_W-1:0] rd_q;
  logic [4:0]                 cnt_q;  // shift steps left
  logic                       is_shift, done;
  logic [31:0]                alu_y, shift_y;

  assign exe_ready = !busy;
  assign accept    = issue_valid && exe_ready;
  assign busy_rd   = busy ? rd_q : '0;
  assign is_shift  = op_q inside {pipe_pkg::ALU_SLL, pipe_pkg::ALU_SRL, pipe_pkg::ALU_SRA};
  assign done      = !is_shift || cnt_q == 5'd0;

  always_comb begin
    case (op_q)
      pipe_pkg::ALU_SUB:  alu_y = acc_q - b_q;
      pipe_pkg::ALU_AND:  alu_y = acc_q & b_q;
      pipe_pkg::ALU_OR:   alu_y = acc_q | b_q;
      pipe_pkg::ALU_XOR:  alu_y = acc_q ^ b_q;
      pipe_pkg::ALU_SLT:  alu_y = {31'b0, $signed(acc_q) < $signed(b_q)};
      pipe_pkg::ALU_SLTU: alu_y = {31'b0, acc_q < b_q};
      default:            alu_y = acc_q + b_q;
    endcase
    case (op_q)
      pipe_pkg::ALU_SLL: shift_y = {acc_q[30:0], 1'b0};
      pipe_pkg::ALU_SRL: shift_y = {1'b0, acc_q[31:1]};
      default:           shift_y = {acc_q[31], acc_q[31:1]};  // sra
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      busy         <= 1'b0;
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= busy && done;
      if (accept) busy <= 1'b1;
      else if (done) busy <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      op_q  <= issue_op;
      acc_q <= issue_a;
      b_q   <= issue_b;
      pc_q  <= issue_pc;
      rd_q  <= issue_rd;
      cnt_q <= issue_b[4:0];
    end else if (busy && !done) begin
      acc_q <= shift_y;  // one bit per cycle
      cnt_q <= cnt_q - 5'd1;
    end
    if (busy && done) begin
      retire_rd   <= rd_q;
      retire_data <= is_shift ? acc_q : alu_y;
      retire_pc   <= pc_q;
    end
  end

endmodule

`default_nettype wire

// File: verilog/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       inst_valid,
  input  logic [31:0]                inst,
  input  logic [31:0]                inst_pc,
  output logic                       inst_ready,
  output logic                       retire_valid,
  output logic [pipe_pkg::REG_W-1:0] retire_rd,
  output logic [31:0]                retire_data,
  output logic [31:0]                retire_pc
);

  logic [pipe_pkg::REG_W-1:0] dec_rs1, dec_rs2, dec_rd;
  logic [31:0]                dec_imm;
  logic [3:0]                 dec_op;
  logic [1:0]                 dec_sel_a;
  logic                       dec_sel_b, dec_uses_rs1, dec_uses_rs2;
  logic [31:0]                rs1_data, rs2_data;
  logic                       issue_valid, exe_ready;
  logic [3:0]                 issue_op;
  logic [31:0]                issue_a, issue_b, issue_pc;
  logic [pipe_pkg::REG_W-1:0] issue_rd, busy_rd;

  inst_decoder i_decoder (
    .inst(inst), .rs1(dec_rs1), .rs2(dec_rs2), .rd(dec_rd), .imm(dec_imm),
    .alu_op(dec_op), .sel_a(dec_sel_a), .sel_b(dec_sel_b),
    .uses_rs1(dec_uses_rs1), .uses_rs2(dec_uses_rs2)
  );

  reg_file i_reg_file (
    .clock(clock), .reset(reset), .rs1(dec_rs1), .rs2(dec_rs2),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .we(retire_valid), .wr_rd(retire_rd), .wr_data(retire_data)  // writeback
  );

  issue_stage i_issue (
    .clock(clock), .reset(reset), .inst_valid(inst_valid), .inst(inst),
    .inst_pc(inst_pc), .inst_ready(inst_ready),
    .dec_rs1(dec_rs1), .dec_rs2(dec_rs2), .dec_rd(dec_rd), .dec_imm(dec_imm),
    .dec_op(dec_op), .dec_sel_a(dec_sel_a), .dec_sel_b(dec_sel_b),
    .dec_uses_rs1(dec_uses_rs1), .dec_uses_rs2(dec_uses_rs2),
    .rs1_data(rs1_data), .rs2_data(rs2_data), .busy_rd(busy_rd),
    .forward_en(retire_valid), .forward_data(retire_data),  // retiring result
    .exe_ready(exe_ready), .issue_valid(issue_valid), .issue_op(issue_op),
    .issue_a(issue_a), .issue_b(issue_b), .issue_rd(issue_rd), .issue_pc(issue_pc)
  );

  alu_execute i_execute (
    .clock(clock), .reset(reset), .issue_valid(issue_valid), .issue_op(issue_op),
    .issue_a(issue_a), .issue_b(issue_b), .issue_pc(issue_pc), .issue_rd(issue_rd),
    .exe_ready(exe_ready), .busy_rd(busy_rd), .retire_valid(retire_valid),
    .retire_rd(retire_rd), .retire_data(retire_data), .retire_pc(retire_pc)
  );

endmodule

`default_nettype wire

// File: verilog/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
  input  riscv_isa_pkg::inst_word_u   inst,
  output logic [pipe_pkg::REG_W-1:0]  rs1,
  output logic [pipe_pkg::REG_W-1:0]  rs2,
  output logic [pipe_pkg::REG_W-1:0]  rd,
  output logic [31:0]                 imm,
  output logic [3:0]                  alu_op,
  output logic [1:0]                  sel_a,
  output logic                        sel_b,
  output logic                        uses_rs1,
  output logic                        uses_rs2
);

  // alt picks sub/sra, sub only exists for register ops
  function automatic logic [3:0] f3_to_op(input logic [2:0] f3, input logic alt,
                                          input logic reg_op);
    logic [3:0] op;
    case (f3)
      riscv_isa_pkg::F3_ADD:  op = (alt && reg_op) ? pipe_pkg::ALU_SUB : pipe_pkg::ALU_ADD;
      riscv_isa_pkg::F3_SLL:  op = pipe_pkg::ALU_SLL;
      riscv_isa_pkg::F3_SLT:  op = pipe_pkg::ALU_SLT;
      riscv_isa_pkg::F3_SLTU: op = pipe_pkg::ALU_SLTU;
      riscv_isa_pkg::F3_XOR:  op = pipe_pkg::ALU_XOR;
      riscv_isa_pkg::F3_SR:   op = alt ? pipe_pkg::ALU_SRA : pipe_pkg::ALU_SRL;
      riscv_isa_pkg::F3_OR:   op = pipe_pkg::ALU_OR;
      default:                op = pipe_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    rs1      = inst.r_fmt.rs1;
    rs2      = inst.r_fmt.rs2;
    rd       = inst.r_fmt.rd;
    imm      = {{20{inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};
    alu_op   = pipe_pkg::ALU_ADD;
    sel_a    = pipe_pkg::SEL_A_RS1;
    sel_b    = pipe_pkg::SEL_B_IMM;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    case (inst.r_fmt.opcode)
      riscv_isa_pkg::OPC_OP: begin
        alu_op   = f3_to_op(inst.r_fmt.funct3, inst.r_fmt.funct7[5], 1'b1);
        sel_b    = pipe_pkg::SEL_B_RS2;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      riscv_isa_pkg::OPC_OP_IMM: begin
        alu_op   = f3_to_op(inst.i_fmt.funct3, inst.i_fmt.imm12[10], 1'b0);  // srai bit
        uses_rs1 = 1'b1;
      end
      riscv_isa_pkg::OPC_LUI: begin
        imm   = {inst.u_fmt.imm20, 12'b0};
        sel_a = pipe_pkg::SEL_A_ZERO;
      end
      riscv_isa_pkg::OPC_AUIPC: begin
        imm   = {inst.u_fmt.imm20, 12'b0};
        sel_a = pipe_pkg::SEL_A_PC;
      end
      default: begin
        // unsupported opcode retires as 0 + 0 into x0
        rd    = '0;
        imm   = '0;
        sel_a = pipe_pkg::SEL_A_ZERO;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       inst_valid,
  input  logic [31:0]                inst,
  input  logic [31:0]                inst_pc,
  output logic                       inst_ready,
  input  logic [pipe_pkg::REG_W-1:0] dec_rs1,
  input  logic [pipe_pkg::REG_W-1:0] dec_rs2,
  input  logic [pipe_pkg::REG_W-1:0] dec_rd,
  input  logic [31:0]                dec_imm,
  input  logic [3:0]                 dec_op,
  input  logic [1:0]                 dec_sel_a,
  input  logic                       dec_sel_b,
  input  logic                       dec_uses_rs1,
  input  logic                       dec_uses_rs2,
  input  logic [31:0]                rs1_data,
  input  logic [31:0]                rs2_data,
  input  logic [pipe_pkg::REG_W-1:0] busy_rd,
  input  logic                       forward_en,
  input  logic [31:0]                forward_data,
  input  logic                       exe_ready,
  output logic                       issue_valid,
  output logic [3:0]                 issue_op,
  output logic [31:0]                issue_a,
  output logic [31:0]                issue_b,
  output logic [pipe_pkg::REG_W-1:0] issue_rd,
  output logic [31:0]                issue_pc
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT,
    HAZARD
  } state_e;

  state_e      state, state_next;
  logic        accept;
  logic [1:0]  hazard_d, hazard_q;  // bit 0 operand a, bit 1 operand b
  logic [31:0] op_a, op_b;

  assign accept = inst_valid && inst_ready;

  always_comb begin
    hazard_d = 2'b00;
    if (busy_rd != '0 && !forward_en) begin
      hazard_d[0] = dec_uses_rs1 && (dec_rs1 == busy_rd);
      hazard_d[1] = dec_uses_rs2 && (dec_rs2 == busy_rd);
    end
  end

  always_comb begin
    case (dec_sel_a)
      pipe_pkg::SEL_A_RS1: op_a = rs1_data;
      pipe_pkg::SEL_A_PC:  op_a = inst_pc;
      default:             op_a = 32'b0;
    endcase
    op_b = (dec_sel_b == pipe_pkg::SEL_B_RS2) ? rs2_data : dec_imm;
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE:    if (accept) state_next = (|hazard_d) ? HAZARD : WAIT;
      WAIT:    if (exe_ready) state_next = IDLE;
      HAZARD:  if (forward_en) state_next = WAIT;
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state       <= IDLE;
      inst_ready  <= 1'b0;
      issue_valid <= 1'b0;
      hazard_q    <= 2'b00;
    end else begin
      state <= state_next;
      case (state)
        IDLE: begin
          inst_ready  <= !accept;
          issue_valid <= accept && !(|hazard_d);
          if (accept) hazard_q <= hazard_d;
        end
        WAIT: begin
          inst_ready  <= exe_ready;  // reopen once execute takes it
          issue_valid <= !exe_ready;
        end
        HAZARD: begin
          inst_ready  <= 1'b0;
          issue_valid <= forward_en;
        end
        default: begin
          inst_ready  <= 1'b0;
          issue_valid <= 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == IDLE && accept) begin
      issue_op <= dec_op;
      issue_a  <= op_a;
      issue_b  <= op_b;
      issue_rd <= dec_rd;
      issue_pc <= inst_pc;
    end else if (state == HAZARD && forward_en) begin
      if (hazard_q[0]) issue_a <= forward_data;
      if (hazard_q[1]) issue_b <= forward_data;  // both may match
    end
  end

endmodule

`default_nettype wire

// File: verilog/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

  localparam int REG_W = 5;

  // alu operation codes
  localparam logic [3:0] ALU_ADD  = 4'd0;
  localparam logic [3:0] ALU_SUB  = 4'd1;
  localparam logic [3:0] ALU_AND  = 4'd2;
  localparam logic [3:0] ALU_OR   = 4'd3;
  localparam logic [3:0] ALU_XOR  = 4'd4;
  localparam logic [3:0] ALU_SLT  = 4'd5;
  localparam logic [3:0] ALU_SLTU = 4'd6;
  localparam logic [3:0] ALU_SLL  = 4'd7;
  localparam logic [3:0] ALU_SRL  = 4'd8;
  localparam logic [3:0] ALU_SRA  = 4'd9;

  // operand a source
  localparam logic [1:0] SEL_A_RS1  = 2'd0;
  localparam logic [1:0] SEL_A_PC   = 2'd1;
  localparam logic [1:0] SEL_A_ZERO = 2'd2;

  // operand b source
  localparam logic SEL_B_IMM = 1'b0;
  localparam logic SEL_B_RS2 = 1'b1;

endpackage

`default_nettype wire

// File: verilog/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic                       clock,
  input  logic                       reset,
  input  logic [pipe_pkg::REG_W-1:0] rs1,
  input  logic [pipe_pkg::REG_W-1:0] rs2,
  output logic [31:0]                rs1_data,
  output logic [31:0]                rs2_data,
  input  logic                       we,
  input  logic [pipe_pkg::REG_W-1:0] wr_rd,
  input  logic [31:0]                wr_data
);

  logic [31:0] regs [32];
  logic        wr_live;

  assign wr_live = we && (wr_rd != '0);  // x0 is never written

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[wr_rd] <= wr_data;
    end
  end

  // same-cycle write passes straight through
  assign rs1_data = (rs1 == '0) ? '0 : (wr_live && wr_rd == rs1) ? wr_data : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : (wr_live && wr_rd == rs2) ? wr_data : regs[rs2];

endmodule

`default_nettype wire

// File: verilog/riscv_isa_pkg.sv
`default_nettype none

package riscv_isa_pkg;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

  localparam logic [2:0] F3_ADD  = 3'b000;  // add, sub, addi
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;  // srl and sra
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [19:0] imm20;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    u_fmt_t u_fmt;
  } inst_word_u;

endpackage

`default_nettype wire
